// ==== source/alut_pkg.sv ====
`default_nettype none

package alut_pkg;

   // ----------------------------
   // table geometry and masks
   // ----------------------------
   localparam int HASH_W      = 8;    // xor-fold of the six address bytes
   localparam int TABLE_DEPTH = 256;  // one entry per hash value
   localparam int PORT_W      = 2;    // four ethernet ports
   localparam int DPORT_W     = 5;    // bit 4 is the switch itself

   localparam logic [DPORT_W-1:0] DPORT_FLOOD  = 5'b0_1111;  // all four ethernet ports
   localparam logic [DPORT_W-1:0] DPORT_SWITCH = 5'b1_0000;  // frame for the switch

   // one table entry, valid bit on top
   typedef struct packed {
      logic              valid;
      logic [31:0]       stamp;  // curr_time when learned
      logic [PORT_W-1:0] port;
      logic [47:0]       addr;
   } alut_entry_t;

   // lookup and learn command from the host
   typedef struct packed {
      logic [47:0]       d_addr;  // address to look up
      logic [47:0]       s_addr;  // address to learn
      logic [PORT_W-1:0] s_port;  // port the frame came in on
   } frame_cmd_t;

   // address checker states
   typedef enum logic [3:0] {
      st_idle,
      st_mac_chk,    // own mac address compare
      st_read_dest,  // dest hash on the table
      st_valid_chk,
      st_age_chk,    // waits for the age checker
      st_addr_chk,   // full address compare, result out
      st_read_src,   // look at the entry about to be replaced
      st_write_src,
      st_done        // ack held until req drops
   } chk_state_e;

endpackage

`default_nettype wire

// ==== source/alut_time_counter.sv ====
`default_nettype none

module alut_time_counter
#(
   parameter int unsigned TICK_DIV = 4  // clocks per time unit
)
(
   input  wire         pclk30,
   input  wire         n_p_reset30,
   output logic [31:0] curr_time      // wraps, age math is modulo 2^32
);

   localparam int unsigned PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [PRE_W-1:0] pre_cnt;  // prescaler
   logic             tick;

   assign tick = (pre_cnt == PRE_W'(TICK_DIV - 1));

   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         pre_cnt   <= '0;
         curr_time <= '0;
      end
      else if (tick)
      begin
         pre_cnt   <= '0;
         curr_time <= curr_time + 32'd1;
      end
      else
      begin
         pre_cnt <= pre_cnt + PRE_W'(1);
      end
   end

endmodule

`default_nettype wire

// ==== source/alut_age_checker.sv ====
`default_nettype none

module alut_age_checker
(
   input  wire        pclk30,
   input  wire        n_p_reset30,
   input  wire [31:0] max_age,     // oldest stamp still in date
   input  wire [31:0] curr_time,
   input  wire        age_req,     // four-phase request from the checker
   input  wire [31:0] last_stamp,  // stable while age_req is high
   output logic       age_ack,
   output logic       age_ok       // valid while age_ack is high
);

   logic [31:0] elapsed;
   logic        in_date;

   // ----------------------------
   // age compare
   // ----------------------------
   // plain subtraction handles a wrapped time counter
   assign elapsed = curr_time - last_stamp;
   assign in_date = (elapsed <= max_age);

   // ----------------------------
   // responder side of the handshake
   // ----------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         age_ack <= 1'b0;
         age_ok  <= 1'b0;
      end
      else if (age_req && !age_ack)
      begin
         age_ack <= 1'b1;     // answer one clock after req
         age_ok  <= in_date;  // verdict registered with the ack
      end
      else if (!age_req)
      begin
         age_ack <= 1'b0;     // req gone, close the handshake
         age_ok  <= 1'b0;
      end
      // otherwise hold ack and verdict until req falls
   end

endmodule

`default_nettype wire

// ==== source/alut_table.sv ====
`default_nettype none

module alut_table
(
   input  wire                         pclk30,
   input  wire                         n_p_reset30,
   input  wire [alut_pkg::HASH_W-1:0]  mem_addr,
   input  wire                         mem_write,
   input  wire alut_pkg::alut_entry_t  mem_wdata,
   output alut_pkg::alut_entry_t       rdata      // registered read
);
   import alut_pkg::*;

   alut_entry_t             mem [TABLE_DEPTH];  // payload only
   logic [TABLE_DEPTH-1:0]  valid_vec;          // empty table after reset
   alut_entry_t             rd_entry;
   logic                    rd_valid;

   // ----------------------------
   // payload array
   // ----------------------------
   always_ff @(posedge pclk30)
   begin
      if (mem_write)
         mem[mem_addr] <= mem_wdata;
      rd_entry <= mem[mem_addr];  // old data on a same-cycle write
   end

   // ----------------------------
   // valid bits
   // ----------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         valid_vec <= '0;
         rd_valid  <= 1'b0;
      end
      else
      begin
         if (mem_write)
            valid_vec[mem_addr] <= mem_wdata.valid;
         rd_valid <= valid_vec[mem_addr];
      end
   end

   // valid vector overrides the stored valid field
   always_comb
   begin
      rdata       = rd_entry;
      rdata.valid = rd_valid;
   end

endmodule

`default_nettype wire

// ==== source/alut_addr_checker.sv ====
`default_nettype none

module alut_addr_checker
(
   input  wire                          pclk30,
   input  wire                          n_p_reset30,
   input  wire [47:0]                   mac_addr,      // switch's own address
   input  wire                          cmd_req,
   input  wire alut_pkg::frame_cmd_t    cmd,
   output logic                         cmd_ack,
   output logic [alut_pkg::DPORT_W-1:0] d_port,        // result port mask
   output logic                         check_active,
   input  wire                          clear_reused,
   output logic                         reused,        // sticky, live entry displaced
   output logic [47:0]                  lst_inv_addr,
   output logic [alut_pkg::PORT_W-1:0]  lst_inv_port,
   input  wire [31:0]                   curr_time,
   output logic                         age_req,
   output logic [31:0]                  last_stamp,    // stamp of the dest entry
   input  wire                          age_ack,
   input  wire                          age_ok,
   output logic [alut_pkg::HASH_W-1:0]  mem_addr,
   output logic                         mem_write,
   output alut_pkg::alut_entry_t        mem_wdata,
   input  wire alut_pkg::alut_entry_t   rdata          // one cycle after mem_addr
);
   import alut_pkg::*;

   chk_state_e          state;
   chk_state_e          nxt_state;
   frame_cmd_t          cmd_q;      // command held for the whole lookup
   logic                entry_ok;   // dest entry valid and in date
   logic [HASH_W-1:0]   d_hash;
   logic [HASH_W-1:0]   s_hash;
   logic [DPORT_W-1:0]  s_mask;     // never send back out the source port
   logic                mac_hit;

   // xor of the six address bytes
   function automatic logic [HASH_W-1:0] fold_hash(input logic [47:0] addr);
      logic [HASH_W-1:0] h;
      h = '0;
      for (int i = 0; i < 48 / HASH_W; i++)
      begin
         h ^= addr[i*HASH_W +: HASH_W];
      end
      return h;
   endfunction

   assign d_hash  = fold_hash(cmd_q.d_addr);
   assign s_hash  = fold_hash(cmd_q.s_addr);
   assign s_mask  = DPORT_W'(1) << cmd_q.s_port;
   assign mac_hit = (cmd_q.d_addr == mac_addr);

   // ----------------------------
   // next state
   // ----------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         st_idle:      if (cmd_req) nxt_state = st_mac_chk;
         st_mac_chk:   nxt_state = mac_hit ? st_done : st_read_dest;  // own frames not learned
         st_read_dest: nxt_state = st_valid_chk;
         st_valid_chk: nxt_state = rdata.valid ? st_age_chk : st_addr_chk;
         st_age_chk:   if (age_ack) nxt_state = st_addr_chk;
         st_addr_chk:  nxt_state = st_read_src;
         st_read_src:  nxt_state = st_write_src;
         st_write_src: nxt_state = st_done;
         st_done:      if (cmd_ack && !cmd_req) nxt_state = st_idle;
         default:      nxt_state = st_idle;
      endcase
   end

   // ----------------------------
   // state, handshakes, port mask
   // ----------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         state    <= st_idle;
         cmd_ack  <= 1'b0;
         d_port   <= DPORT_FLOOD;
         age_req  <= 1'b0;
         entry_ok <= 1'b0;
      end
      else
      begin
         state <= nxt_state;
         case (state)
            st_mac_chk:
               if (mac_hit)
                  d_port <= DPORT_SWITCH;
            st_valid_chk:
            begin
               entry_ok <= rdata.valid;
               age_req  <= rdata.valid;   // last_stamp loads on the same edge
            end
            st_age_chk:
               if (age_ack)
               begin
                  age_req  <= 1'b0;
                  entry_ok <= age_ok;     // stale entry treated as a miss
               end
            st_addr_chk:
               // rdata still holds the dest entry here
               if (entry_ok && (rdata.addr == cmd_q.d_addr))
                  d_port <= (DPORT_W'(1) << rdata.port) & ~s_mask;
               else
                  d_port <= DPORT_FLOOD & ~s_mask;
            st_done:
               if (!cmd_ack)
                  cmd_ack <= 1'b1;
               else if (!cmd_req)
                  cmd_ack <= 1'b0;        // back to idle on this edge
            default:
               ;
         endcase
      end
   end

   // ----------------------------
   // reuse tracking
   // ----------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if ((state == st_read_src) && rdata.valid && (rdata.addr != cmd_q.s_addr))
      begin
         reused       <= 1'b1;            // set wins over clear
         lst_inv_addr <= rdata.addr;
         lst_inv_port <= rdata.port;
      end
      else if (clear_reused)
      begin
         reused <= 1'b0;
      end
   end

   // command latch and stamp for the age check
   always_ff @(posedge pclk30)
   begin
      if ((state == st_idle) && cmd_req)
         cmd_q <= cmd;
      if (state == st_valid_chk)
         last_stamp <= rdata.stamp;
   end

   // source hash from addr_chk on, so read_src sees the source entry
   assign mem_addr = (state inside {st_addr_chk, st_read_src, st_write_src}) ? s_hash : d_hash;
   assign mem_write    = (state == st_write_src);
   assign check_active = (state != st_idle);

   // learned entries are always valid, stamped now
   assign mem_wdata = '{valid: 1'b1,
                        stamp: curr_time,
                        port:  cmd_q.s_port,
                        addr:  cmd_q.s_addr};

endmodule

`default_nettype wire

// ==== source/alut_top.sv ====
`default_nettype none

module alut_top
#(
   parameter int unsigned TICK_DIV = 4  // time counter prescale
)
(
   input  wire                          pclk30,
   input  wire                          n_p_reset30,
   input  wire [47:0]                   mac_addr,
   input  wire [31:0]                   max_age,
   input  wire                          cmd_req,
   input  wire alut_pkg::frame_cmd_t    cmd,
   output logic                         cmd_ack,
   output logic [alut_pkg::DPORT_W-1:0] d_port,
   output logic                         check_active,
   input  wire                          clear_reused,
   output logic                         reused,
   output logic [47:0]                  lst_inv_addr,
   output logic [alut_pkg::PORT_W-1:0]  lst_inv_port
);
   import alut_pkg::*;

   // ----------------------------
   // internal nets
   // ----------------------------
   logic [31:0]        curr_time;   // shared time base
   logic               age_req;
   logic               age_ack;
   logic               age_ok;
   logic [31:0]        last_stamp;
   logic [HASH_W-1:0]  mem_addr;
   logic               mem_write;
   alut_entry_t        mem_wdata;
   alut_entry_t        rdata;

   // lookup and learn fsm
   alut_addr_checker u_addr_checker
   (
      .pclk30       (pclk30),
      .n_p_reset30  (n_p_reset30),
      .mac_addr     (mac_addr),
      .cmd_req      (cmd_req),
      .cmd          (cmd),
      .cmd_ack      (cmd_ack),
      .d_port       (d_port),
      .check_active (check_active),
      .clear_reused (clear_reused),
      .reused       (reused),
      .lst_inv_addr (lst_inv_addr),
      .lst_inv_port (lst_inv_port),
      .curr_time    (curr_time),
      .age_req      (age_req),
      .last_stamp   (last_stamp),
      .age_ack      (age_ack),
      .age_ok       (age_ok),
      .mem_addr     (mem_addr),
      .mem_write    (mem_write),
      .mem_wdata    (mem_wdata),
      .rdata        (rdata)
   );

   alut_age_checker u_age_checker
   (
      .pclk30      (pclk30),
      .n_p_reset30 (n_p_reset30),
      .max_age     (max_age),
      .curr_time   (curr_time),
      .age_req     (age_req),
      .last_stamp  (last_stamp),
      .age_ack     (age_ack),
      .age_ok      (age_ok)
   );

   alut_time_counter #(
      .TICK_DIV (TICK_DIV)
   ) u_time_counter (
      .pclk30      (pclk30),
      .n_p_reset30 (n_p_reset30),
      .curr_time   (curr_time)
   );

   alut_table u_table
   (
      .pclk30      (pclk30),
      .n_p_reset30 (n_p_reset30),
      .mem_addr    (mem_addr),
      .mem_write   (mem_write),
      .mem_wdata   (mem_wdata),
      .rdata       (rdata)
   );

endmodule

`default_nettype wire

// ==== tests/alut_model.svh ====
`ifndef ALUT_MODEL_SVH
`define ALUT_MODEL_SVH

// ------------------------------
// shadow table, one slot per hash
// ------------------------------
logic [47:0]        own_mac = 48'h02_aa_bb_cc_dd_ee;  // driven onto mac_addr
logic               shadow_valid [TABLE_DEPTH];
logic [47:0]        shadow_addr  [TABLE_DEPTH];
logic [PORT_W-1:0]  shadow_port  [TABLE_DEPTH];
int                 shadow_cycle [TABLE_DEPTH];  // tb cycle when learned
logic               exp_reused;                  // expected sticky flag
logic [47:0]        exp_inv_addr;
logic [PORT_W-1:0]  exp_inv_port;

// six address bytes xor'ed together
function automatic logic [HASH_W-1:0] addr_hash(input logic [47:0] a);
   return a[47:40] ^ a[39:32] ^ a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
endfunction

function automatic logic [DPORT_W-1:0] port_bit(input logic [PORT_W-1:0] p);
   return DPORT_W'(1) << p;  // one-hot of an ethernet port
endfunction

// all ones never ages; zero is stale once the time counter surely moved
function automatic bit in_date(input int idx, input int now);
   if (max_age == '1)
      return 1'b1;
   return (now - shadow_cycle[idx]) < 2 * TICK_DIV;
endfunction

// port mask for a command issued at cycle now
function automatic logic [DPORT_W-1:0] expect_port(input frame_cmd_t c, input int now);
   logic [HASH_W-1:0] h;
   h = addr_hash(c.d_addr);
   if (c.d_addr == own_mac)
      return DPORT_SWITCH;
   if (shadow_valid[h] && in_date(int'(h), now) && (shadow_addr[h] == c.d_addr))
      return port_bit(shadow_port[h]) & ~port_bit(c.s_port);  // known station
   return DPORT_FLOOD & ~port_bit(c.s_port);
endfunction

// learn the source, frames for the switch itself are not learned
task automatic learn_source(input frame_cmd_t c, input int now);
   logic [HASH_W-1:0] h;
   h = addr_hash(c.s_addr);
   if (c.d_addr == own_mac)
      return;
   if (shadow_valid[h] && (shadow_addr[h] != c.s_addr))
   begin
      exp_reused   = 1'b1;            // live entry of another station displaced
      exp_inv_addr = shadow_addr[h];
      exp_inv_port = shadow_port[h];
   end
   shadow_valid[h] = 1'b1;
   shadow_addr[h]  = c.s_addr;
   shadow_port[h]  = c.s_port;
   shadow_cycle[h] = now;
endtask

task automatic model_reset();
   for (int i = 0; i < TABLE_DEPTH; i++)
   begin
      shadow_valid[i] = 1'b0;
      shadow_cycle[i] = 0;
   end
   exp_reused   = 1'b0;
   exp_inv_addr = '0;
   exp_inv_port = '0;
endtask

`endif

// ==== tests/alut_tb.sv ====
`default_nettype none

module alut_tb;
   import alut_pkg::*;

   localparam int TICK_DIV = 4;
   localparam int N_CMDS   = 227;                                // 1 + 2 + 200 + 16 + 8
   localparam int IDLE_CYC = 4 + 200 * 3 + 8 * 2 * TICK_DIV + 64;  // reset, gaps, clears
   localparam int MAX_CYC  = 20 * N_CMDS + IDLE_CYC;

   logic               pclk30 = 1'b0;
   logic               n_p_reset30;
   logic [47:0]        mac_addr;
   logic [31:0]        max_age;
   logic               cmd_req;
   frame_cmd_t         cmd;
   logic               cmd_ack;
   logic [DPORT_W-1:0] d_port;
   logic               check_active;
   logic               clear_reused;
   logic               reused;
   logic [47:0]        lst_inv_addr;
   logic [PORT_W-1:0]  lst_inv_port;

   int                 seed   = 32'h6ebf;
   int                 cycle  = 0;
   int                 errors = 0;
   int                 checks = 0;
   logic [47:0]        pool [12];  // pool[i] and pool[i+6] share a hash

   `include "alut_model.svh"

   alut_top #(.TICK_DIV(TICK_DIV)) uut (.*);

   always #50 pclk30 = ~pclk30;

   // cycle count, also the time base of the model
   always @(posedge pclk30)
   begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYC)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYC);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   function automatic int pick(input int n);
      int r;
      r = $random(seed);
      return int'($unsigned(r) % n);
   endfunction

   function automatic frame_cmd_t make_cmd(input logic [47:0] d, input logic [47:0] s,
                                           input int p);
      frame_cmd_t c;
      c.d_addr = d;
      c.s_addr = s;
      c.s_port = PORT_W'(p);
      return c;
   endfunction

   function automatic frame_cmd_t random_cmd();
      frame_cmd_t c;
      c.d_addr = (pick(16) == 0) ? own_mac : pool[pick(12)];  // now and then a frame for us
      c.s_addr = pool[pick(12)];
      c.s_port = PORT_W'(pick(4));
      return c;
   endfunction

   // ------------------------------
   // four-phase command driver
   // ------------------------------
   task automatic run_cmd(input frame_cmd_t c, input int hold,
                          output logic [DPORT_W-1:0] seen);
      logic [DPORT_W-1:0] exp_port;
      @(posedge pclk30);
      exp_port = expect_port(c, cycle);  // dest lookup comes before the learn
      cmd     <= c;
      cmd_req <= 1'b1;
      @(posedge pclk30);
      while (!cmd_ack)
         @(posedge pclk30);
      seen = d_port;
      check_value("d_port", 64'(d_port), 64'(exp_port));
      check_value("check_active", 64'(check_active), 64'd1);
      for (int i = 0; i < hold; i++)
      begin
         @(posedge pclk30);
         check_value("cmd_ack", 64'(cmd_ack), 64'd1);    // req still high
         check_value("d_port", 64'(d_port), 64'(exp_port));
      end
      cmd_req <= 1'b0;
      learn_source(c, cycle);
      @(posedge pclk30);
      while (cmd_ack)
         @(posedge pclk30);
      check_value("check_active", 64'(check_active), 64'd0);
      check_value("reused", 64'(reused), 64'(exp_reused));
      check_value("lst_inv_addr", 64'(lst_inv_addr), 64'(exp_inv_addr));
      check_value("lst_inv_port", 64'(lst_inv_port), 64'(exp_inv_port));
   endtask

   task automatic pulse_clear();
      @(posedge pclk30);
      clear_reused <= 1'b1;
      @(posedge pclk30);
      clear_reused <= 1'b0;
      exp_reused = 1'b0;
      @(posedge pclk30);
      check_value("reused", 64'(reused), 64'd0);
   endtask

   task automatic end_test(input string name, input int first_err);
      if (errors == first_err)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - first_err);
   endtask

   initial
   begin
      logic [DPORT_W-1:0] seen;
      int                 first_err;
      int                 idx [4];  // four different hashes
      n_p_reset30  = 1'b0;
      mac_addr     = own_mac;
      max_age      = '1;
      cmd_req      = 1'b0;
      cmd          = '0;
      clear_reused = 1'b0;
      idx          = '{1, 2, 10, 11};
      for (int i = 0; i < 6; i++)
      begin
         pool[i]     = {40'h02_1c_40_00_00, 8'(8'h10 + 3 * i)};
         pool[i + 6] = pool[i] ^ 48'h00_00_33_33_00_00;  // same hash, other station
      end
      model_reset();
      repeat (4) @(posedge pclk30);
      n_p_reset30 <= 1'b1;

      // 1 reset values, ack held while req stays high
      first_err = errors;
      @(posedge pclk30);
      check_value("cmd_ack", 64'(cmd_ack), 64'd0);
      check_value("check_active", 64'(check_active), 64'd0);
      check_value("reused", 64'(reused), 64'd0);
      check_value("d_port", 64'(d_port), 64'(DPORT_FLOOD));
      run_cmd(make_cmd(pool[1], pool[2], 0), 2, seen);
      end_test("1 reset and handshake", first_err);

      // 2 own address goes to the switch and is not learned
      first_err = errors;
      run_cmd(make_cmd(own_mac, pool[3], 2), 0, seen);
      check_value("d_port", 64'(seen), 64'(DPORT_SWITCH));
      run_cmd(make_cmd(pool[3], pool[5], 1), 1, seen);
      check_value("d_port", 64'(seen), 64'(DPORT_FLOOD & ~5'b00010));
      end_test("2 own mac", first_err);

      // ------------------------------
      // 3 random traffic, no aging
      // ------------------------------
      first_err = errors;
      for (int n = 0; n < 200; n++)
      begin
         repeat (pick(4)) @(posedge pclk30);
         run_cmd(random_cmd(), pick(3), seen);
      end
      end_test("3 random lookups", first_err);

      // 4 reuse flag, pool[0] and pool[6] fight for one slot
      first_err = errors;
      pulse_clear();
      run_cmd(make_cmd(pool[7], pool[0], 1), 0, seen);
      pulse_clear();
      run_cmd(make_cmd(pool[8], pool[0], 1), 0, seen);
      check_value("reused", 64'(reused), 64'd0);       // same station again
      run_cmd(make_cmd(pool[0], pool[6], 2), 0, seen);
      check_value("reused", 64'(reused), 64'd1);
      check_value("lst_inv_addr", 64'(lst_inv_addr), 64'(pool[0]));
      check_value("lst_inv_port", 64'(lst_inv_port), 64'd1);
      run_cmd(make_cmd(pool[9], pool[6], 3), 0, seen);
      check_value("reused", 64'(reused), 64'd1);       // sticky
      pulse_clear();
      for (int n = 0; n < 12; n++)
      begin
         if (pick(3) == 0)
            pulse_clear();
         run_cmd(random_cmd(), 0, seen);
      end
      end_test("4 reuse flag", first_err);

      // ------------------------------
      // 5 zero max age, every hit is stale
      // ------------------------------
      first_err = errors;
      @(posedge pclk30);
      max_age <= '0;
      for (int n = 0; n < 8; n++)
      begin
         repeat (2 * TICK_DIV) @(posedge pclk30);
         if (n < 4)
         begin
            run_cmd(make_cmd(pool[0], pool[idx[n]], n), 0, seen);
         end
         else
         begin
            run_cmd(make_cmd(pool[idx[n - 4]], pool[3], n - 4), 0, seen);
            check_value("d_port", 64'(seen), 64'(DPORT_FLOOD & ~port_bit(PORT_W'(n - 4))));
         end
      end
      end_test("5 aged entries", first_err);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
source/alut_pkg.sv
source/alut_time_counter.sv
source/alut_age_checker.sv
source/alut_table.sv
source/alut_addr_checker.sv
source/alut_top.sv
tests/alut_tb.sv

// ==== Makefile ====
# verilator flow for the address lookup block, override any variable on the command line
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= alut_tb
RTL_TOP   ?= alut_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
